// File: src/u1_core_pkg.sv
`default_nettype none

package u1_core_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // wishbone geometry
   localparam int WB_DW = 16;
   localparam int WB_AW = 11;
   localparam int WB_SW = 2;
   localparam int DEC_W = 4;      // region field, top of byte address

   // region codes, settings spans 8 and 9
   localparam logic [DEC_W-1:0] REGION_MISC     = 4'd0;
   localparam logic [DEC_W-1:0] REGION_READBACK = 4'd7;
   localparam logic [DEC_W-1:0] REGION_SETTINGS = 4'd8;

   ////////////////////////////////////////////////////////////////////////////
   // misc slave byte offsets
   localparam logic [6:0] REG_LEDS      = 7'd0;
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;   // read only
   localparam logic [6:0] REG_TEST      = 7'd8;
   localparam logic [6:0] REG_COMPAT    = 7'd16;  // read only

   localparam logic [7:0]  COMPAT_NUM      = 8'd5;
   localparam logic [15:0] MISC_DEFAULT    = 16'hBEEF;
   localparam logic [15:0] CGEN_CTRL_RESET = 16'd3;

   ////////////////////////////////////////////////////////////////////////////
   // settings bus
   localparam int SET_AW = 8;
   localparam int SET_DW = 32;

   // only 64 settings registers exist, 6 address bits
   localparam logic [SET_AW-1:0] SR_TIME64     = 8'd42;  // +0 ctrl, +2 hi, +3 lo
   localparam logic [SET_AW-1:0] SR_REG_TEST32 = 8'd60;

   typedef logic [63:0]       time_t;
   typedef logic [SET_AW-1:0] set_addr_t;
   typedef logic [SET_DW-1:0] set_data_t;

endpackage

`default_nettype wire

// File: src/wb16_if.sv
`default_nettype none

interface wb16_if;
   import u1_core_pkg::*;

   logic [WB_AW-1:0] adr;
   logic [WB_DW-1:0] dat_mosi;
   logic [WB_DW-1:0] dat_miso;
   logic [WB_SW-1:0] sel;
   logic             we;
   logic             cyc;
   logic             stb;
   logic             ack;

   // decoder side
   modport master (output adr, dat_mosi, sel, we, cyc, stb,
                   input  dat_miso, ack);

   // slave side
   modport slave  (input  adr, dat_mosi, sel, we, cyc, stb,
                   output dat_miso, ack);

endinterface

`default_nettype wire

// File: src/wb_slave_decoder.sv
`default_nettype none

module wb_slave_decoder
  (
   input  wire                           wb_clk,
   input  wire                           wb_rst,
   input  wire  [u1_core_pkg::WB_AW-1:0] wb_adr_i,
   input  wire  [u1_core_pkg::WB_DW-1:0] wb_dat_i,
   input  wire  [u1_core_pkg::WB_SW-1:0] wb_sel_i,
   input  wire                           wb_we_i,
   input  wire                           wb_cyc_i,
   input  wire                           wb_stb_i,
   output logic [u1_core_pkg::WB_DW-1:0] wb_dat_o,
   output logic                          wb_ack_o,
   wb16_if.master                        misc_o,
   wb16_if.master                        readback_o,
   wb16_if.master                        settings_o
   );

   import u1_core_pkg::*;

   logic [DEC_W-1:0] region;
   logic             hit_misc;
   logic             hit_readback;
   logic             hit_settings;

   assign region       = wb_adr_i[WB_AW-1 -: DEC_W];
   assign hit_misc     = (region == REGION_MISC);
   assign hit_readback = (region == REGION_READBACK);
   assign hit_settings = (region[DEC_W-1:1] == REGION_SETTINGS[DEC_W-1:1]);  // 8 and 9

   // shared request lines, only stb is steered
   assign misc_o.adr      = wb_adr_i;
   assign misc_o.dat_mosi = wb_dat_i;
   assign misc_o.sel      = wb_sel_i;
   assign misc_o.we       = wb_we_i;
   assign misc_o.cyc      = wb_cyc_i;
   assign misc_o.stb      = wb_stb_i & hit_misc;

   assign readback_o.adr      = wb_adr_i;
   assign readback_o.dat_mosi = wb_dat_i;
   assign readback_o.sel      = wb_sel_i;
   assign readback_o.we       = wb_we_i;
   assign readback_o.cyc      = wb_cyc_i;
   assign readback_o.stb      = wb_stb_i & hit_readback;

   assign settings_o.adr      = wb_adr_i;
   assign settings_o.dat_mosi = wb_dat_i;
   assign settings_o.sel      = wb_sel_i;
   assign settings_o.we       = wb_we_i;
   assign settings_o.cyc      = wb_cyc_i;
   assign settings_o.stb      = wb_stb_i & hit_settings;

   // return path, unmapped regions never ack
   always_comb
   begin
      wb_ack_o = 1'b0;
      wb_dat_o = '0;
      if (hit_misc)
      begin
         wb_ack_o = misc_o.ack;
         wb_dat_o = misc_o.dat_miso;
      end
      else if (hit_readback)
      begin
         wb_ack_o = readback_o.ack;
         wb_dat_o = readback_o.dat_miso;
      end
      else if (hit_settings)
      begin
         wb_ack_o = settings_o.ack;
         wb_dat_o = settings_o.dat_miso;
      end
   end

   a_one_slave: assert property (@(posedge wb_clk) disable iff (wb_rst)
      $onehot0({misc_o.stb, readback_o.stb, settings_o.stb}));

endmodule

`default_nettype wire

// File: src/misc_regs.sv
`default_nettype none

module misc_regs
  (
   input  wire        wb_clk,
   input  wire        wb_rst,
   wb16_if.slave      bus_i,
   input  wire        cgen_st_status_i,
   input  wire        cgen_st_ld_i,
   input  wire        cgen_st_refmon_i,
   output logic [2:0] debug_led_o,
   output logic       cgen_sync_b_o,
   output logic       cgen_ref_sel_o
   );

   import u1_core_pkg::*;

   logic [15:0] reg_leds;
   logic [15:0] reg_cgen_ctrl;
   logic [15:0] reg_test;
   logic [6:0]  offset;
   logic        wr;

   assign offset = bus_i.adr[6:0];
   assign wr     = bus_i.cyc & bus_i.stb & bus_i.we;

   ////////////////////////////////////////////////////////////////////////////
   // control registers

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= CGEN_CTRL_RESET;   // sync_b and ref_sel idle high
         reg_test      <= '0;
      end
      else if (wr)
      begin
         case (offset)
            REG_LEDS      : reg_leds      <= bus_i.dat_mosi;
            REG_CGEN_CTRL : reg_cgen_ctrl <= bus_i.dat_mosi;
            REG_TEST      : reg_test      <= bus_i.dat_mosi;
            default       : ;
         endcase
      end
   end

   // leds are wired out of order on the board
   assign {debug_led_o[2], debug_led_o[0], debug_led_o[1]} = reg_leds[2:0];
   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];

   ////////////////////////////////////////////////////////////////////////////
   // readback

   always_comb
   begin
      case (offset)
         REG_LEDS      : bus_i.dat_miso = reg_leds;
         REG_CGEN_CTRL : bus_i.dat_miso = reg_cgen_ctrl;
         REG_CGEN_ST   : bus_i.dat_miso = {13'd0, cgen_st_status_i, cgen_st_ld_i,
                                           cgen_st_refmon_i};
         REG_TEST      : bus_i.dat_miso = reg_test;
         REG_COMPAT    : bus_i.dat_miso = {8'd0, COMPAT_NUM};
         default       : bus_i.dat_miso = MISC_DEFAULT;
      endcase
   end

   assign bus_i.ack = bus_i.cyc & bus_i.stb;   // no wait states

endmodule

`default_nettype wire

// File: src/settings_bus_16le.sv
`default_nettype none

module settings_bus_16le
  (
   input  wire                    wb_clk,
   input  wire                    wb_rst,
   wb16_if.slave                  bus_i,
   output logic                   set_stb_o,
   output u1_core_pkg::set_addr_t set_addr_o,
   output u1_core_pkg::set_data_t set_data_o
   );

   import u1_core_pkg::*;

   logic [15:0] low_half;
   logic        wr;
   logic        wr_low;
   logic        wr_high;

   assign wr      = bus_i.cyc & bus_i.stb & bus_i.we;
   assign wr_low  = wr & ~bus_i.adr[1];
   assign wr_high = wr &  bus_i.adr[1];   // completes the 32 bit word

   // low half waits here for its partner
   always_ff @(posedge wb_clk)
   begin
      if (wr_low)
         low_half <= bus_i.dat_mosi;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr_high;
   end

   // address is the 32 bit word index, 6 bits
   always_ff @(posedge wb_clk)
   begin
      if (wr_high)
      begin
         set_addr_o <= set_addr_t'(bus_i.adr[7:2]);
         set_data_o <= {bus_i.dat_mosi, low_half};
      end
   end

   assign bus_i.dat_miso = '0;   // write only
   assign bus_i.ack      = bus_i.cyc & bus_i.stb;

   a_stb_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_stb_o |=> !set_stb_o);

endmodule

`default_nettype wire

// File: src/vita_timer.sv
`default_nettype none

module vita_timer
  (
   input  wire                    wb_clk,
   input  wire                    wb_rst,
   input  wire                    pps_i,
   input  wire                    set_stb_i,
   input  wire u1_core_pkg::set_addr_t set_addr_i,
   input  wire u1_core_pkg::set_data_t set_data_i,
   output u1_core_pkg::time_t     vita_time_o,
   output u1_core_pkg::time_t     vita_time_pps_o
   );

   import u1_core_pkg::*;

   logic [31:0] time_hi;      // staged upper word
   logic [31:0] time_lo;      // lower word held while armed
   logic        pps_mode;
   logic        armed;
   logic        hit_ctrl;
   logic        hit_hi;
   logic        hit_lo;
   logic        load_now;
   logic        load_pps;
   logic [1:0]  pps_sync;
   logic        pps_d;
   logic        pps_edge;

   ////////////////////////////////////////////////////////////////////////////
   // settings decode

   assign hit_ctrl = set_stb_i & (set_addr_i == SR_TIME64);
   assign hit_hi   = set_stb_i & (set_addr_i == SR_TIME64 + 8'd2);
   assign hit_lo   = set_stb_i & (set_addr_i == SR_TIME64 + 8'd3);
   assign load_now = hit_lo & ~pps_mode;
   assign load_pps = armed & pps_edge;

   always_ff @(posedge wb_clk)
   begin
      if (hit_hi)
         time_hi <= set_data_i;
      if (hit_lo)
         time_lo <= set_data_i;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_mode <= 1'b0;
         armed    <= 1'b0;
      end
      else
      begin
         if (hit_ctrl)
            pps_mode <= set_data_i[0];
         if (hit_lo & pps_mode)
            armed <= 1'b1;        // wait for next pps
         else if (pps_edge)
            armed <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // pps sync and rising edge

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sync <= '0;
         pps_d    <= 1'b0;
      end
      else
      begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_d    <= pps_sync[1];
      end
   end

   assign pps_edge = pps_sync[1] & ~pps_d;

   // time counter and pps latch
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
      end
      else
      begin
         if (load_now)
            vita_time_o <= {time_hi, set_data_i};
         else if (load_pps)
            vita_time_o <= {time_hi, time_lo};
         else
            vita_time_o <= vita_time_o + 64'd1;
         if (pps_edge)
            vita_time_pps_o <= vita_time_o;
      end
   end

   a_time_step: assert property (@(posedge wb_clk) disable iff (wb_rst)
      !(load_now || load_pps) |=> vita_time_o == $past(vita_time_o) + 64'd1);

endmodule

`default_nettype wire

// File: src/readback_mux_16le.sv
`default_nettype none

module readback_mux_16le
  (
   input  wire                         wb_clk,
   input  wire                         wb_rst,
   wb16_if.slave                       bus_i,
   input  wire                         set_stb_i,
   input  wire u1_core_pkg::set_addr_t set_addr_i,
   input  wire u1_core_pkg::set_data_t set_data_i,
   input  wire u1_core_pkg::time_t     vita_time_i,
   input  wire u1_core_pkg::time_t     vita_time_pps_i
   );

   import u1_core_pkg::*;

   set_data_t   reg_test32;
   logic [31:0] word;
   logic [15:0] hold_hi;     // upper half taken with the low read
   logic        rd_low;

   ////////////////////////////////////////////////////////////////////////////
   // test setting

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         reg_test32 <= '0;
      else if (set_stb_i && (set_addr_i == SR_REG_TEST32))
         reg_test32 <= set_data_i;
   end

   ////////////////////////////////////////////////////////////////////////////
   // word select, 32 bit words at byte address bits 5:2

   always_comb
   begin
      case (bus_i.adr[5:2])
         4'd0    : word = vita_time_i[63:32];
         4'd1    : word = vita_time_i[31:0];
         4'd2    : word = vita_time_pps_i[63:32];
         4'd3    : word = vita_time_pps_i[31:0];
         4'd4    : word = reg_test32;
         default : word = '0;
      endcase
   end

   assign rd_low = bus_i.cyc & bus_i.stb & ~bus_i.we & ~bus_i.adr[1];

   // both halves come from the same cycle
   always_ff @(posedge wb_clk)
   begin
      if (rd_low)
         hold_hi <= word[31:16];
   end

   assign bus_i.dat_miso = bus_i.adr[1] ? hold_hi : word[15:0];
   assign bus_i.ack      = bus_i.cyc & bus_i.stb;

endmodule

`default_nettype wire

// File: src/u1_core_top.sv
`default_nettype none

module u1_core_top
  (
   input  wire                           wb_clk,
   input  wire                           wb_rst,
   input  wire  [u1_core_pkg::WB_AW-1:0] wb_adr_i,
   input  wire  [u1_core_pkg::WB_DW-1:0] wb_dat_i,
   input  wire  [u1_core_pkg::WB_SW-1:0] wb_sel_i,
   input  wire                           wb_we_i,
   input  wire                           wb_cyc_i,
   input  wire                           wb_stb_i,
   output logic [u1_core_pkg::WB_DW-1:0] wb_dat_o,
   output logic                          wb_ack_o,
   input  wire                           cgen_st_status_i,
   input  wire                           cgen_st_ld_i,
   input  wire                           cgen_st_refmon_i,
   input  wire                           pps_i,
   output logic [2:0]                    debug_led_o,
   output logic                          cgen_sync_b_o,
   output logic                          cgen_ref_sel_o
   );

   import u1_core_pkg::*;

   wb16_if misc_bus ();
   wb16_if readback_bus ();
   wb16_if settings_bus ();

   logic      set_stb;
   set_addr_t set_addr;
   set_data_t set_data;
   time_t     vita_time;
   time_t     vita_time_pps;

   ////////////////////////////////////////////////////////////////////////////
   // host bus and slaves

   wb_slave_decoder decoder
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
      .wb_we_i(wb_we_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .misc_o(misc_bus), .readback_o(readback_bus), .settings_o(settings_bus));

   misc_regs misc
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .bus_i(misc_bus),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i), .debug_led_o(debug_led_o),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o));

   settings_bus_16le settings
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .bus_i(settings_bus),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   readback_mux_16le readback
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .bus_i(readback_bus),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps));

   ////////////////////////////////////////////////////////////////////////////
   // time base, lives on the settings bus

   vita_timer timer
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .pps_i(pps_i),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

endmodule

`default_nettype wire

// File: tests/tb_u1_core.sv
`default_nettype none

module tb_u1_core;
   import u1_core_pkg::*;

   localparam int DRV         = 10;   // input skew after the rising edge
   localparam int ACK_TIMEOUT = 16;

   logic             wb_clk;
   logic             wb_rst;
   logic [WB_AW-1:0] wb_adr_i;
   logic [WB_DW-1:0] wb_dat_i;
   logic [WB_SW-1:0] wb_sel_i;
   logic             wb_we_i;
   logic             wb_cyc_i;
   logic             wb_stb_i;
   logic             cgen_st_status_i;
   logic             cgen_st_ld_i;
   logic             cgen_st_refmon_i;
   logic             pps_i;
   wire  [WB_DW-1:0] wb_dat_o;
   wire              wb_ack_o;
   wire  [2:0]       debug_led_o;
   wire              cgen_sync_b_o;
   wire              cgen_ref_sel_o;

   logic [31:0] seed;
   int          checks;
   int          errors;
   int          timeouts;
   logic [63:0] got_q[$];
   logic [63:0] exp_q[$];
   string       name_q[$];

   // shadow copy of the misc slave
   logic [15:0] sh_leds;
   logic [15:0] sh_ctrl;
   logic [15:0] sh_test;
   logic [2:0]  sh_st;

   u1_core_top uut
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
      .wb_we_i(wb_we_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i), .pps_i(pps_i),
      .debug_led_o(debug_led_o), .cgen_sync_b_o(cgen_sync_b_o),
      .cgen_ref_sel_o(cgen_ref_sel_o));

   always #50 wb_clk = ~wb_clk;

   ////////////////////////////////////////////////////////////////////////////
   // reference model and comparison

   function automatic logic [31:0] rand32();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic logic [15:0] misc_ref(input logic [6:0] off, input logic [15:0] leds,
                                            input logic [15:0] ctrl, input logic [15:0] test,
                                            input logic [2:0] st);
      case (off)
         REG_LEDS      : return leds;
         REG_CGEN_CTRL : return ctrl;
         REG_CGEN_ST   : return {13'd0, st};     // status, ld, refmon
         REG_TEST      : return test;
         REG_COMPAT    : return 16'h0005;
         default       : return 16'hBEEF;
      endcase
   endfunction

   task automatic expect_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      name_q.push_back(name);
      got_q.push_back(got);
      exp_q.push_back(exp);
   endtask

   // drains queued comparisons once per clock
   always @(posedge wb_clk)
   begin : compare_proc
      logic [63:0] got;
      logic [63:0] exp;
      string       name;
      while (got_q.size() != 0)
      begin
         got  = got_q.pop_front();
         exp  = exp_q.pop_front();
         name = name_q.pop_front();
         checks++;
         assert (got === exp)
         else
         begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         end
      end
   end

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond)
      else
      begin
         errors++;
         $display("%0t: %s", $time, what);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // host bus

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge wb_clk);
         #DRV;
      end
   endtask

   // one transfer that starts and ends just after a rising edge
   task automatic bus_xfer(input logic [WB_AW-1:0] adr, input logic we,
                           input logic [15:0] wdat, output logic [15:0] rdat);
      int   n;
      logic acked;
      wb_adr_i = adr;
      wb_we_i  = we;
      wb_dat_i = wdat;
      wb_sel_i = 2'b11;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      rdat     = '0;
      acked    = 1'b0;
      n        = 0;
      while (!acked && n < ACK_TIMEOUT)
      begin
         @(negedge wb_clk);            // ack and data settled mid cycle
         if (wb_ack_o)
         begin
            acked = 1'b1;
            rdat  = wb_dat_o;
         end
         @(posedge wb_clk);
         #DRV;
         n++;
      end
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      if (!acked)
      begin
         timeouts++;
         $display("%0t: no ack for bus address %h", $time, adr);
      end
   endtask

   task automatic host_write(input logic [WB_AW-1:0] adr, input logic [15:0] dat);
      logic [15:0] unused;
      bus_xfer(adr, 1'b1, dat, unused);
   endtask

   task automatic host_read(input logic [WB_AW-1:0] adr, output logic [15:0] dat);
      bus_xfer(adr, 1'b0, 16'h0, dat);
   endtask

   task automatic write_setting(input set_addr_t sa, input logic [31:0] val);
      host_write({REGION_SETTINGS[DEC_W-1:1], sa[5:0], 2'b00}, val[15:0]);
      host_write({REGION_SETTINGS[DEC_W-1:1], sa[5:0], 2'b10}, val[31:16]);
      idle_cycles(2);   // strobe and then the consumer register
   endtask

   task automatic read_word(input logic [3:0] w, output logic [31:0] val);
      logic [15:0] lo;
      logic [15:0] hi;
      host_read({REGION_READBACK, 1'b0, w, 2'b00}, lo);
      host_read({REGION_READBACK, 1'b0, w, 2'b10}, hi);
      val = {hi, lo};
   endtask

   // lower word first as the upper word cannot carry during the read
   task automatic read_pair(input logic [3:0] w_hi, input logic [3:0] w_lo,
                            output logic [63:0] val);
      logic [31:0] lo;
      logic [31:0] hi;
      read_word(w_lo, lo);
      read_word(w_hi, hi);
      val = {hi, lo};
   endtask

   task automatic check_misc(input logic [6:0] off, input string name);
      logic [15:0] d;
      host_read({4'd0, off}, d);
      expect_val(name, d, misc_ref(off, sh_leds, sh_ctrl, sh_test, sh_st));
   endtask

   task automatic check_pins();
      expect_val("debug_led_o", debug_led_o, {sh_leds[2], sh_leds[0], sh_leds[1]});
      expect_val("cgen_sync_b_o", cgen_sync_b_o, sh_ctrl[1]);
      expect_val("cgen_ref_sel_o", cgen_ref_sel_o, sh_ctrl[0]);
   endtask

   task automatic pulse_pps();
      pps_i = 1'b1;
      idle_cycles(4);
      pps_i = 1'b0;
      idle_cycles(4);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus

   initial
   begin : main
      logic [31:0] v;
      logic [31:0] rd;
      logic [63:0] t_load;
      logic [63:0] t0;
      logic [63:0] t1;
      logic [63:0] tp;
      int          n;
      int          pick;
      wb_clk   = 1'b0;
      wb_rst   = 1'b1;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = '0;
      wb_we_i  = 1'b0;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      {cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i} = 3'b000;
      pps_i    = 1'b0;
      seed     = 32'h2e7a_5655;
      checks   = 0;
      errors   = 0;
      timeouts = 0;
      sh_leds  = '0;
      sh_ctrl  = 16'h0003;
      sh_test  = '0;
      sh_st    = '0;

      repeat (16) @(posedge wb_clk);
      #DRV;
      wb_rst = 1'b0;

      // reset values
      check_misc(REG_LEDS, "leds");
      check_misc(REG_CGEN_CTRL, "cgen_ctrl");
      check_misc(REG_TEST, "test");
      check_misc(REG_COMPAT, "compat");
      check_misc(7'd2, "unmapped offset 2");
      check_misc(7'd12, "unmapped offset 12");
      check_pins();

      // random register writes
      for (n = 0; n < 12; n++)
      begin
         pick = int'(rand32() % 32'd3);
         v    = rand32();
         case (pick)
            0 : sh_leds = v[15:0];
            1 : sh_ctrl = v[15:0];
            default : sh_test = v[15:0];
         endcase
         host_write({4'd0, (pick == 0) ? REG_LEDS : (pick == 1) ? REG_CGEN_CTRL : REG_TEST},
                    v[15:0]);
         check_pins();
         check_misc(REG_LEDS, "leds");
         check_misc(REG_CGEN_CTRL, "cgen_ctrl");
         check_misc(REG_TEST, "test");
      end

      for (n = 0; n < 4; n++)
      begin
         v     = rand32();
         sh_st = v[2:0];
         {cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i} = sh_st;
         check_misc(REG_CGEN_ST, "cgen_st");
      end

      // 32 bit test setting through the readback slave
      v = rand32();
      write_setting(SR_REG_TEST32, v);
      read_word(4'd4, rd);
      expect_val("test32 readback", rd, v);

      // immediate load with the top bits cleared so nothing carries
      v = rand32();
      t_load[63:32] = {1'b0, v[30:0]};
      v = rand32();
      t_load[31:0]  = {1'b0, v[30:0]};
      write_setting(SR_TIME64, 32'd0);
      write_setting(SR_TIME64 + 8'd2, t_load[63:32]);
      write_setting(SR_TIME64 + 8'd3, t_load[31:0]);
      read_pair(4'd0, 4'd1, t0);
      check_true(t0 >= t_load && t0 < t_load + 64, "time after immediate load out of range");
      read_pair(4'd0, 4'd1, t1);
      check_true(t1 > t0, "time did not increase between two reads");

      // pps capture
      read_pair(4'd0, 4'd1, t0);
      pulse_pps();
      read_pair(4'd0, 4'd1, t1);
      read_pair(4'd2, 4'd3, tp);
      check_true(tp >= t0 && tp <= t1, "pps time not between the surrounding time reads");

      // load armed for the next pps edge
      v = rand32();
      t_load[63:32] = {1'b0, v[30:0]};
      v = rand32();
      t_load[31:0]  = {1'b0, v[30:0]};
      write_setting(SR_TIME64, 32'd1);
      write_setting(SR_TIME64 + 8'd2, t_load[63:32]);
      write_setting(SR_TIME64 + 8'd3, t_load[31:0]);
      read_pair(4'd0, 4'd1, t0);
      check_true(t0 > t1 && t0 < t1 + 1000, "time did not keep running while armed");
      pulse_pps();
      read_pair(4'd0, 4'd1, t0);
      check_true(t0 >= t_load && t0 < t_load + 64, "time after pps load out of range");

      // let the checker catch up
      n = 0;
      while (got_q.size() != 0 && n < 8)
      begin
         @(negedge wb_clk);
         n++;
      end
      if (got_q.size() != 0)
      begin
         timeouts++;
         $display("comparison queue did not drain");
      end

      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
src/u1_core_pkg.sv
src/wb16_if.sv
src/wb_slave_decoder.sv
src/misc_regs.sv
src/settings_bus_16le.sv
src/vita_timer.sv
src/readback_mux_16le.sv
src/u1_core_top.sv
tests/tb_u1_core.sv

// File: Bender.yml
package:
  name: u1_core

sources:
  - src/u1_core_pkg.sv
  - src/wb16_if.sv
  - src/wb_slave_decoder.sv
  - src/misc_regs.sv
  - src/settings_bus_16le.sv
  - src/vita_timer.sv
  - src/readback_mux_16le.sv
  - src/u1_core_top.sv

  - target: test
    files:
      - tests/tb_u1_core.sv
